// ==== afi_read_path.f ====
hdl/afi_read_path_pkg.sv
hdl/rdata_en_delay_line.sv
hdl/read_valid_select.sv
hdl/oct_control.sv
hdl/afi_read_path.sv
verif/afi_read_path_assert.sv
verif/afi_read_path_checker.sv
verif/afi_read_path_tb.sv

// ==== Bender.yml ====
package:
  name: afi_read_path

sources:
  - target: rtl
    files:
      - hdl/afi_read_path_pkg.sv
      - hdl/rdata_en_delay_line.sv
      - hdl/read_valid_select.sv
      - hdl/oct_control.sv
      - hdl/afi_read_path.sv
  - target: verif
    files:
      - verif/afi_read_path_assert.sv
      - verif/afi_read_path_checker.sv
      - verif/afi_read_path_tb.sv

// ==== verif/afi_read_path_tb.sv ====
`timescale 1ns/1ps

// Testbench for the read datapath, table driven with one read pattern per row
module afi_read_path_tb
	import afi_read_path_pkg::*;
();

	localparam int NUM_TESTS = 6;
	localparam int IDLE_CYCLES = 3;
	localparam int DONE_TIMEOUT = 64;

	// One row of the stimulus table
	typedef struct packed {
		lat_count_t latency;
		logic [3:0] en_len;
		logic [3:0] full_len;
		afi_data_t data;
	} test_row_t;

	logic pll_afi_clk;
	logic reset_n_afi_clk;
	rate_vec_t afi_rdata_en;
	rate_vec_t afi_rdata_en_full;
	lat_count_t read_latency;
	afi_data_t ddio_phy_dq;
	afi_data_t afi_rdata;
	afi_data_t phy_mux_read_fifo_q;
	rate_vec_t afi_rdata_valid;
	oct_vec_t force_oct_off;
	logic test_start;
	logic chk_done;
	int test_count;
	int error_count;
	integer seed;
	test_row_t table_q [NUM_TESTS];

	afi_read_path dut_i (
		.pll_afi_clk                (pll_afi_clk),
		.reset_n_afi_clk            (reset_n_afi_clk),
		.afi_rdata_en_i             (afi_rdata_en),
		.afi_rdata_en_full_i        (afi_rdata_en_full),
		.seq_read_latency_counter_i (read_latency),
		.ddio_phy_dq_i              (ddio_phy_dq),
		.afi_rdata_o                (afi_rdata),
		.phy_mux_read_fifo_q_o      (phy_mux_read_fifo_q),
		.afi_rdata_valid_o          (afi_rdata_valid),
		.force_oct_off_o            (force_oct_off)
	);

	afi_read_path_checker u_checker (
		.pll_afi_clk                (pll_afi_clk),
		.reset_n_afi_clk            (reset_n_afi_clk),
		.afi_rdata_en_i             (afi_rdata_en),
		.afi_rdata_en_full_i        (afi_rdata_en_full),
		.seq_read_latency_counter_i (read_latency),
		.ddio_phy_dq_i              (ddio_phy_dq),
		.afi_rdata_o                (afi_rdata),
		.phy_mux_read_fifo_q_o      (phy_mux_read_fifo_q),
		.afi_rdata_valid_o          (afi_rdata_valid),
		.force_oct_off_o            (force_oct_off),
		.test_start_i               (test_start),
		.test_done_o                (chk_done),
		.test_count_o               (test_count),
		.error_count_o              (error_count)
	);

	bind afi_read_path afi_read_path_assert u_assert (.*);

	initial
	begin
		pll_afi_clk = 1'b0;
		forever
		begin
			#2 pll_afi_clk = ~pll_afi_clk;
		end
	end

	// Fill one table row, drawing the low data word first
	task automatic fill_row(input int idx, input int lat, input int en_len, input int full_len);
		logic [31:0] lo_word;
		logic [31:0] hi_word;
		lo_word = $random(seed);
		hi_word = $random(seed);
		table_q[idx] = '{latency: lat, en_len: en_len, full_len: full_len,
			data: {hi_word, lo_word}};
	endtask

	// ************************************************************
	// Apply one row and wait for the checker to close it
	// ************************************************************

	task automatic run_row(input test_row_t row, output bit timed_out);
		int span;
		int waited;
		span = (row.en_len > row.full_len) ? row.en_len : row.full_len;
		@(posedge pll_afi_clk);
		read_latency <= row.latency;
		test_start <= 1'b1;
		@(posedge pll_afi_clk);
		test_start <= 1'b0;
		repeat (IDLE_CYCLES) @(posedge pll_afi_clk);
		for (int c = 0; c < span; c++)
		begin
			ddio_phy_dq <= row.data;
			afi_rdata_en <= (c < row.en_len) ? 2'b11 : 2'b00;
			afi_rdata_en_full <= (c < row.full_len) ? 2'b11 : 2'b00;
			@(posedge pll_afi_clk);
		end
		afi_rdata_en <= '0;
		afi_rdata_en_full <= '0;
		waited = 0;
		while (!chk_done && waited < DONE_TIMEOUT)
		begin
			@(posedge pll_afi_clk);
			waited++;
		end
		timed_out = !chk_done;
	endtask

	initial
	begin
		bit timed_out;
		int total_errs;
		seed = 86349;
		timed_out = 1'b0;
		reset_n_afi_clk = 1'b0;
		afi_rdata_en = '0;
		afi_rdata_en_full = '0;
		read_latency = '0;
		ddio_phy_dq = '0;
		test_start = 1'b0;
		// Latency, read enable length, full enable length
		fill_row(0, 0, 1, 1);
		fill_row(1, 5, 1, 0);
		fill_row(2, 15, 1, 2);
		fill_row(3, 3, 4, 3);
		fill_row(4, 9, 0, 5);
		fill_row(5, 7, 3, 1);
		repeat (16) @(posedge pll_afi_clk);
		reset_n_afi_clk <= 1'b1;
		for (int i = 0; i < NUM_TESTS && !timed_out; i++)
		begin
			run_row(table_q[i], timed_out);
			if (timed_out)
			begin
				$display("timeout, checker did not finish test %0d", i);
			end
		end
		total_errs = error_count + dut_i.u_assert.fail_count;
		$display("tests %0d, errors %0d", test_count, total_errs);
		if (!timed_out && total_errs == 0)
		begin
			$display("TEST PASSED");
		end
		else
		begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// ==== verif/afi_read_path_checker.sv ====
`timescale 1ns/1ps

// Scoreboard for the read datapath.
// Shadow histories of the read enables are built from the DUT input ports,
// and the expected outputs follow from the latency and termination rules
module afi_read_path_checker
	import afi_read_path_pkg::*;
(
	input  logic        pll_afi_clk,
	input  logic        reset_n_afi_clk,
	input  rate_vec_t   afi_rdata_en_i,
	input  rate_vec_t   afi_rdata_en_full_i,
	input  lat_count_t  seq_read_latency_counter_i,
	input  afi_data_t   ddio_phy_dq_i,
	input  afi_data_t   afi_rdata_o,
	input  afi_data_t   phy_mux_read_fifo_q_o,
	input  rate_vec_t   afi_rdata_valid_o,
	input  oct_vec_t    force_oct_off_o,
	input  logic        test_start_i,
	output logic        test_done_o,
	output int          test_count_o,
	output int          error_count_o
);

	// Oldest enable that can still reach the valid output
	localparam int VALID_DEPTH = MAX_READ_LATENCY + 2;

	// Bit 0 holds the enable sampled at the current edge
	logic [VALID_DEPTH-1:0] en_hist;
	logic [OCT_OFF_DELAY:0] full_hist;

	// Expected outputs after the current edge
	rate_vec_t exp_valid;
	oct_vec_t exp_oct;

	// Test bookkeeping
	logic busy;
	logic seen_read;
	int test_errs;
	int err_total;
	int tests_done;

	assign test_count_o = tests_done;
	assign error_count_o = err_total;

	// Beat of group k in slot t moves from offset 32k+8t to offset 16t+8k
	function automatic afi_data_t slot_major(input afi_data_t word);
		afi_data_t remapped;
		remapped = '0;
		for (int k = 0; k < MEM_READ_DQS_WIDTH; k++)
		begin
			for (int t = 0; t < NUM_TIMESLOTS; t++)
			begin
				remapped[16*t + 8*k +: 8] = word[32*k + 8*t +: 8];
			end
		end
		return remapped;
	endfunction

	// Compare one output and log a mismatch
	task automatic check_field(input string name, input afi_data_t got, input afi_data_t exp);
		if (got !== exp)
		begin
			$display("[ERROR] %s expected 0x%h got 0x%h", name, exp, got);
			err_total++;
			test_errs++;
		end
	endtask

	// ************************************************************
	// Compare at the edge, then advance the shadow model
	// ************************************************************

	always @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			en_hist = '0;
			full_hist = '0;
			exp_valid = '0;
			exp_oct = '0;
			busy = 1'b0;
			seen_read = 1'b0;
			test_errs = 0;
			err_total = 0;
			tests_done = 0;
			test_done_o <= 1'b0;
		end
		else
		begin
			// Outputs still show the values from the previous edge here
			check_field("afi_rdata_valid_o", afi_data_t'(afi_rdata_valid_o),
				afi_data_t'(exp_valid));
			check_field("force_oct_off_o", afi_data_t'(force_oct_off_o), afi_data_t'(exp_oct));
			check_field("afi_rdata_o", afi_rdata_o, slot_major(ddio_phy_dq_i));
			check_field("phy_mux_read_fifo_q_o", phy_mux_read_fifo_q_o, ddio_phy_dq_i);
			if (test_start_i)
			begin
				busy = 1'b1;
				seen_read = 1'b0;
				test_errs = 0;
				test_done_o <= 1'b0;
			end
			en_hist = {en_hist[VALID_DEPTH-2:0], afi_rdata_en_i[0]};
			full_hist = {full_hist[OCT_OFF_DELAY-1:0], afi_rdata_en_full_i[0]};
			if (en_hist != '0 || full_hist != '0)
			begin
				seen_read = 1'b1;
			end
			// Valid follows the enable by latency plus two edges
			exp_valid = {AFI_RATE_RATIO{en_hist[int'(seq_read_latency_counter_i) + 2]}};
			// Termination stays on while an enable sits inside the window
			exp_oct = {AFI_DQS_WIDTH{~(|full_hist[OCT_OFF_DELAY:OCT_ON_DELAY])}};
			// A test ends once every token of its reads has drained out
			if (busy && seen_read && en_hist == '0 && full_hist == '0)
			begin
				$display("test %0d latency %0d: %0d mismatches", tests_done,
					seq_read_latency_counter_i, test_errs);
				busy = 1'b0;
				tests_done++;
				test_done_o <= 1'b1;
			end
		end
	end

endmodule

// ==== verif/afi_read_path_assert.sv ====
`timescale 1ns/1ps

// Structural properties of the read datapath outputs, bound into the top level
module afi_read_path_assert
	import afi_read_path_pkg::*;
(
	input  logic       pll_afi_clk,
	input  logic       reset_n_afi_clk,
	input  rate_vec_t  afi_rdata_valid_o,
	input  oct_vec_t   force_oct_off_o,
	input  afi_data_t  ddio_phy_dq_i,
	input  afi_data_t  phy_mux_read_fifo_q_o
);

	// Number of assertion failures, read by the testbench at the end of the run
	int fail_count = 0;

	// ************************************************************
	// Reset values
	// ************************************************************

	// The cycle after reset is released still shows the reset values
	reset_values: assert property (@(posedge pll_afi_clk)
		$rose(reset_n_afi_clk) |-> (afi_rdata_valid_o == '0 && force_oct_off_o == '0))
	else
	begin
		$error("outputs not cleared by reset");
		fail_count++;
	end

	// ************************************************************
	// Output consistency
	// ************************************************************

	// One shared latency means both phases always agree
	valid_phases_equal: assert property (@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		afi_rdata_valid_o == {AFI_RATE_RATIO{afi_rdata_valid_o[0]}})
	else
	begin
		$error("read valid phases differ");
		fail_count++;
	end

	// Every strobe shares the same termination window
	oct_bits_equal: assert property (@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		force_oct_off_o == {AFI_DQS_WIDTH{force_oct_off_o[0]}})
	else
	begin
		$error("termination control bits differ");
		fail_count++;
	end

	// The sequencer bus is the group-major capture bus passed straight through
	fifo_q_passthrough: assert property (@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		phy_mux_read_fifo_q_o == ddio_phy_dq_i)
	else
	begin
		$error("sequencer read bus differs from the capture bus");
		fail_count++;
	end

endmodule

// ==== hdl/afi_read_path.sv ====
`timescale 1ns/1ps

// AFI-side read datapath of the DDR3 PHY.
// The read FIFOs sit in the I/O block, so the captured data arrives already in
// the AFI clock domain and only needs reordering here.
// The module also delays the read enable into the read valid and drives
// the on-die termination control around each read.
module afi_read_path
	import afi_read_path_pkg::*;
(
	input  logic        pll_afi_clk,
	input  logic        reset_n_afi_clk,
	input  rate_vec_t   afi_rdata_en_i,
	input  rate_vec_t   afi_rdata_en_full_i,
	input  lat_count_t  seq_read_latency_counter_i,
	input  afi_data_t   ddio_phy_dq_i,
	output afi_data_t   afi_rdata_o,
	output afi_data_t   phy_mux_read_fifo_q_o,
	output rate_vec_t   afi_rdata_valid_o,
	output oct_vec_t    force_oct_off_o
);

	// Width of one DQS group across all time slots of an AFI cycle
	localparam int GROUP_DATA_WIDTH = NUM_TIMESLOTS * DQ_GROUP_WIDTH;

	// Read command from the controller
	afi_read_cmd_t read_cmd;

	// Delay line contents handed to the valid selector
	lat_taps_t taps;

	assign read_cmd.rdata_en = afi_rdata_en_i;
	assign read_cmd.rdata_en_full = afi_rdata_en_full_i;

	// ************************************************************
	// Read valid path
	// ************************************************************

	rdata_en_delay_line u_delay_line (
		.pll_afi_clk     (pll_afi_clk),
		.reset_n_afi_clk (reset_n_afi_clk),
		.rdata_en_i      (read_cmd.rdata_en),
		.taps_o          (taps)
	);

	// One selector serves all groups since they share the latency counter
	read_valid_select u_valid_select (
		.pll_afi_clk       (pll_afi_clk),
		.reset_n_afi_clk   (reset_n_afi_clk),
		.taps_i            (taps),
		.latency_count_i   (seq_read_latency_counter_i),
		.afi_rdata_valid_o (afi_rdata_valid_o)
	);

	// ************************************************************
	// Termination control
	// ************************************************************

	oct_control u_oct_control (
		.pll_afi_clk     (pll_afi_clk),
		.reset_n_afi_clk (reset_n_afi_clk),
		.rdata_en_full_i (read_cmd.rdata_en_full),
		.force_oct_off_o (force_oct_off_o)
	);

	// ************************************************************
	// Read data mapping
	// ************************************************************

	// The DDIO bus is ordered by DQS group and sub-ordered by time slot.
	// The AFI bus is ordered by time slot and sub-ordered by DQS group.
	// The sequencer bus goes back to group-major order, built from the AFI bus
	for (genvar k = 0; k < MEM_READ_DQS_WIDTH; k++)
	begin : g_group
		for (genvar t = 0; t < NUM_TIMESLOTS; t++)
		begin : g_slot
			// Group k in time slot t as captured by the DDIO
			dq_slice_t ddio_slice;

			// Same beat as seen on the AFI side
			dq_slice_t afi_slice;

			assign ddio_slice = ddio_phy_dq_i[GROUP_DATA_WIDTH*k + DQ_GROUP_WIDTH*t +: DQ_GROUP_WIDTH];

			// Time-slot-major placement for the controller
			assign afi_rdata_o[MEM_DQ_WIDTH*t + DQ_GROUP_WIDTH*k +: DQ_GROUP_WIDTH] = ddio_slice;

			// Pick the beat back out of the AFI bus for calibration
			assign afi_slice = afi_rdata_o[MEM_DQ_WIDTH*t + DQ_GROUP_WIDTH*k +: DQ_GROUP_WIDTH];
			assign phy_mux_read_fifo_q_o[GROUP_DATA_WIDTH*k + DQ_GROUP_WIDTH*t +: DQ_GROUP_WIDTH] =
				afi_slice;
		end
	end

endmodule

// ==== hdl/oct_control.sv ====
`timescale 1ns/1ps

// On-die termination control for reads.
// Keeps a short history of the full read enable and forces termination on
// for the window in which the read burst comes back from the memory.
module oct_control
	import afi_read_path_pkg::*;
(
	input  logic       pll_afi_clk,
	input  logic       reset_n_afi_clk,
	input  rate_vec_t  rdata_en_full_i,
	output oct_vec_t   force_oct_off_o
);

	// ************************************************************
	// Read enable history
	// ************************************************************

	// Bit j holds the full enable from j+1 edges before the current one
	logic [OCT_OFF_DELAY-1:0] hist_q;

	// History with the live input prepended as bit 0
	logic [OCT_OFF_DELAY:0] hist_ext;

	// High while any read in the window is still returning data
	logic oct_window;

	// Registered termination control, one bit per strobe per phase
	oct_vec_t force_q;

	// Phase 0 of the full enable covers the whole AFI cycle in half rate
	assign hist_ext = {hist_q, rdata_en_full_i[0]};

	// The window opens OCT_ON_DELAY cycles after the read enable and closes
	// OCT_OFF_DELAY cycles after it, wrapped around the returning burst.
	// The output register below is the first cycle of that count
	assign oct_window = |hist_ext[OCT_OFF_DELAY:OCT_ON_DELAY];

	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			hist_q <= '0;
			force_q <= '0;
		end
		else
		begin
			// The oldest entry drops off the top
			hist_q <= hist_ext[OCT_OFF_DELAY-1:0];

			// Low keeps termination on, high lets the I/O turn it off
			force_q <= {AFI_DQS_WIDTH{~oct_window}};
		end
	end

	// All strobes share the same window
	assign force_oct_off_o = force_q;

endmodule

// ==== hdl/read_valid_select.sv ====
`timescale 1ns/1ps

// Read valid selector.
// Picks the delay line tap given by the calibrated latency counter and turns
// it into the registered AFI read valid, one bit per AFI phase.
module read_valid_select
	import afi_read_path_pkg::*;
(
	input  logic        pll_afi_clk,
	input  logic        reset_n_afi_clk,
	input  lat_taps_t   taps_i,
	input  lat_count_t  latency_count_i,
	output rate_vec_t   afi_rdata_valid_o
);

	// ************************************************************
	// Tap selection stage
	// ************************************************************

	// Registered copy of the selected tap
	logic sel_q;

	// Registered read valid that leaves the block
	rate_vec_t valid_q;

	// The counter is set by calibration and is held steady while reads are
	// in flight, so the mux select does not change under a live token.
	// The 4-bit counter spans every tap of the 16-deep line
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			sel_q <= 1'b0;
		end
		else
		begin
			// One cycle after the tap reaches the selected depth
			sel_q <= taps_i[latency_count_i];
		end
	end

	// ************************************************************
	// Output stage
	// ************************************************************

	// This register must be kept as its own flop and never merged with a
	// look-alike register elsewhere.
	// Timing constraint scripts find the AFI clock domain through it
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			valid_q <= '0;
		end
		else
		begin
			// Every DQS group shares one latency, so a single bit drives
			// all AFI phases of the valid
			valid_q <= {AFI_RATE_RATIO{sel_q}};
		end
	end

	// A token at the enable input shows up here latency plus two cycles later
	assign afi_rdata_valid_o = valid_q;

endmodule

// ==== hdl/rdata_en_delay_line.sv ====
`timescale 1ns/1ps

// Latency shift register for the read enable.
// Each tap holds the read enable as it was a fixed number of AFI cycles ago,
// so the valid selector can pick any calibrated read latency from it.
module rdata_en_delay_line
	import afi_read_path_pkg::*;
(
	input  logic       pll_afi_clk,
	input  logic       reset_n_afi_clk,
	input  rate_vec_t  rdata_en_i,
	output lat_taps_t  taps_o
);

	// ************************************************************
	// Token shift register
	// ************************************************************

	// Tap k holds the enable sampled k edges before the newest one
	lat_taps_t taps_q;

	// In half rate one AFI cycle of read enable returns two beats per phase,
	// and the controller always raises both phases together.
	// Phase 0 therefore stands for both phase tokens
	logic token_in;

	assign token_in = rdata_en_i[0];

	// The register shifts every cycle whether or not a read is in flight.
	// An idle cycle simply pushes a zero token down the line
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			// No tokens are in flight after reset
			taps_q <= '0;
		end
		else
		begin
			// Newest token enters at bit 0 and ages toward the top
			taps_q <= {taps_q[MAX_READ_LATENCY-2:0], token_in};
		end
	end

	// All taps go out in parallel.
	// The selector decides which one matches the calibrated latency
	assign taps_o = taps_q;

	// Bit 0 of the taps is one cycle behind the enable input.
	// The oldest tap is MAX_READ_LATENCY cycles behind it

endmodule

// ==== hdl/afi_read_path_pkg.sv ====
package afi_read_path_pkg;

	// ************************************************************
	// Interface geometry
	// ************************************************************

	// DQ pins and read strobe groups on the memory side
	localparam int MEM_DQ_WIDTH = 16;
	localparam int MEM_READ_DQS_WIDTH = 2;
	localparam int DQ_GROUP_WIDTH = 8;

	// Half rate core, so every AFI cycle carries two phases and four beats
	localparam int AFI_RATE_RATIO = 2;
	localparam int NUM_TIMESLOTS = 4;
	localparam int AFI_DATA_WIDTH = 64;

	// One termination control per strobe per phase
	localparam int AFI_DQS_WIDTH = 4;

	// ************************************************************
	// Read latency and termination window
	// ************************************************************

	// The delay line is deep enough for any value of the 4-bit counter
	localparam int MAX_READ_LATENCY = 16;
	localparam int LAT_COUNT_WIDTH = 4;

	// Memory read latency in memory clock cycles
	localparam int MEM_T_RL = 11;

	// Termination window in AFI cycles, derived from the read latency
	localparam int OCT_ON_DELAY = (MEM_T_RL > 4) ? ((MEM_T_RL - 4) / 2) : 0;
	localparam int OCT_OFF_DELAY = (MEM_T_RL + 6) / 2;

	// Vector types for widths that carry a meaning
	typedef logic [AFI_DATA_WIDTH-1:0] afi_data_t;
	typedef logic [DQ_GROUP_WIDTH-1:0] dq_slice_t;
	typedef logic [LAT_COUNT_WIDTH-1:0] lat_count_t;
	typedef logic [AFI_RATE_RATIO-1:0] rate_vec_t;
	typedef logic [AFI_DQS_WIDTH-1:0] oct_vec_t;
	typedef logic [MAX_READ_LATENCY-1:0] lat_taps_t;

	// Read command as seen from the controller, one bit per AFI phase
	typedef struct packed {
		rate_vec_t rdata_en;
		rate_vec_t rdata_en_full;
	} afi_read_cmd_t;

endpackage
